// File: include/rv_settings.svh
//**********************************************************
// Core-wide constants for the RV32I subset core
// Included by the RTL and the testbench wherever needed
//**********************************************************
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// First fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000

// Architectural integer registers
`define RV_REG_COUNT 32

`endif

// File: verilog/rv_pkg.sv
//**********************************************************
// Shared types for the core and the fetch/decode interfaces
// Compile before every other RTL file
//**********************************************************
package rv_pkg;
	typedef enum logic [2:0] {
		OP_ALU,
		OP_LOAD,
		OP_STORE,
		OP_BRANCH,
		OP_JAL,
		OP_LUI
	} op_type_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_EQ,	// Branch compare, result in bit 0
		ALU_NE
	} alu_op_e;

	// RV32I major opcodes of the subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
endpackage

// Fetched word handed from fetch to decode
interface fetch_if ();
	logic [31:0]	instr;
	logic [31:0]	pc;
	logic		fetch_valid;	// Held until decode_complete
	logic		decode_complete;	// One-cycle pulse

	modport fetch (output instr, pc, fetch_valid, input decode_complete);
	modport decode (input instr, pc, fetch_valid, output decode_complete);
endinterface

// Operand bundle handed from decode to execute
interface decode_if ();
	logic [31:0]		op_a;
	logic [31:0]		op_b;
	logic [31:0]		op_c;	// Store data or branch/jump offset
	rv_pkg::alu_op_e	op;
	rv_pkg::op_type_e	op_type;
	logic [4:0]		rd;
	logic [31:0]		pc;
	logic			decode_valid;	// Held until instr_complete
	logic			instr_complete;	// One-cycle pulse

	modport decode (output op_a, op_b, op_c, op, op_type, rd, pc, decode_valid,
		input instr_complete);
	modport exec (input op_a, op_b, op_c, op, op_type, rd, pc, decode_valid,
		output instr_complete);
endinterface

// File: verilog/rv_fetch.sv
//**********************************************************
// Instruction fetch: owns the pc and the instruction port
// Holds the fetched word for decode until it is consumed
//**********************************************************
`include "rv_settings.svh"

module rv_fetch (
	input  logic		clock,
	input  logic		reset,
	input  logic [31:0]	next_pc,
	input  logic		instr_complete,
	output logic [31:0]	iaddr,
	input  logic [31:0]	idata,
	output logic		ivalid,
	input  logic		iready,
	fetch_if.fetch		f
);
	logic [31:0]	pc;
	logic		started;	// First request issued after reset
	logic		ifetch_done;

	assign iaddr = pc;	// Stable while ivalid is high
	assign f.pc = pc;
	assign ifetch_done = ivalid && iready;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `RV_RESET_VECTOR;
			started <= 1'b0;
			ivalid <= 1'b0;
		end else begin
			if (!started) begin
				started <= 1'b1;
				ivalid <= 1'b1;	// Request at the reset vector
			end else if (instr_complete) begin
				pc <= next_pc;
				ivalid <= 1'b1;
			end else if (ifetch_done) begin
				ivalid <= 1'b0;
			end
		end
	end

	// Word stays valid until decode has taken it
	always_ff @(posedge clock) begin
		if (reset) begin
			f.fetch_valid <= 1'b0;
		end else begin
			if (ifetch_done) begin
				f.fetch_valid <= 1'b1;
			end else if (f.decode_complete) begin
				f.fetch_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ifetch_done) begin
			f.instr <= idata;
		end
	end

endmodule

// File: verilog/rv_regfile.sv
//**********************************************************
// Integer register file, two async reads and one write
//**********************************************************
`include "rv_settings.svh"

module rv_regfile (
	input  logic		clock,
	input  logic		reset,
	input  logic [4:0]	ra_raddr,
	input  logic [4:0]	rb_raddr,
	output logic [31:0]	ra_rdata,
	output logic [31:0]	rb_rdata,
	input  logic [4:0]	rd_waddr,
	input  logic [31:0]	rd_wdata,
	input  logic		rd_wen
);
	logic [31:0]	regs [`RV_REG_COUNT];

	// x0 is never written, so it reads zero after reset
	assign ra_rdata = regs[ra_raddr];
	assign rb_rdata = regs[rb_raddr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (rd_wen && rd_waddr != 5'd0) begin
				regs[rd_waddr] <= rd_wdata;
			end
		end
	end

endmodule

// File: verilog/rv_decode.sv
//**********************************************************
// Instruction decode and operand fetch
// Turns the fetched word into one operand bundle for exec
//**********************************************************
module rv_decode import rv_pkg::*; (
	input  logic		clock,
	input  logic		reset,
	fetch_if.decode		f,
	output logic [4:0]	ra_raddr,
	output logic [4:0]	rb_raddr,
	input  logic [31:0]	ra_rdata,
	input  logic [31:0]	rb_rdata,
	decode_if.decode	d
);
	logic [6:0]	opcode;
	logic [2:0]	funct3;
	logic		funct7_5;	// Selects SUB over ADD
	logic [31:0]	imm_i;
	logic [31:0]	imm_s;
	logic [31:0]	imm_b;
	logic [31:0]	imm_u;
	logic [31:0]	imm_j;
	op_type_e	op_type_n;
	alu_op_e	op_n;
	logic [31:0]	op_b_n;
	logic [31:0]	op_c_n;
	logic [4:0]	rd_n;
	logic		take;

	assign opcode = f.instr[6:0];
	assign funct3 = f.instr[14:12];
	assign funct7_5 = f.instr[30];
	assign ra_raddr = f.instr[19:15];
	assign rb_raddr = f.instr[24:20];
	assign take = f.fetch_valid && !d.decode_valid;

	assign imm_i = {{20{f.instr[31]}}, f.instr[31:20]};
	assign imm_s = {{20{f.instr[31]}}, f.instr[31:25], f.instr[11:7]};
	assign imm_b = {{19{f.instr[31]}}, f.instr[31], f.instr[7], f.instr[30:25],
		f.instr[11:8], 1'b0};
	assign imm_u = {f.instr[31:12], 12'b0};
	assign imm_j = {{11{f.instr[31]}}, f.instr[31], f.instr[19:12], f.instr[20],
		f.instr[30:21], 1'b0};

	// Anything not recognised falls out as an add to x0
	always_comb begin
		op_type_n = OP_ALU;
		op_n = ALU_ADD;
		op_b_n = imm_i;
		op_c_n = rb_rdata;
		rd_n = f.instr[11:7];
		case (opcode)
			OPC_LUI: begin
				op_type_n = OP_LUI;
				op_b_n = imm_u;
			end
			OPC_OPIMM, OPC_OP: begin
				if (opcode == OPC_OP) op_b_n = rb_rdata;
				case (funct3)
					3'b000: op_n = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
					3'b100: op_n = ALU_XOR;
					3'b110: op_n = ALU_OR;
					3'b111: op_n = ALU_AND;
					default: rd_n = 5'd0;
				endcase
			end
			OPC_LOAD: begin
				if (funct3 == 3'b010) op_type_n = OP_LOAD;	// LW only
				else rd_n = 5'd0;
			end
			OPC_STORE: begin
				rd_n = 5'd0;
				op_b_n = imm_s;
				if (funct3 == 3'b010) op_type_n = OP_STORE;
			end
			OPC_BRANCH: begin
				rd_n = 5'd0;
				op_b_n = rb_rdata;
				op_c_n = imm_b;
				if (funct3 == 3'b000) begin
					op_type_n = OP_BRANCH;
					op_n = ALU_EQ;
				end else if (funct3 == 3'b001) begin
					op_type_n = OP_BRANCH;
					op_n = ALU_NE;
				end
			end
			OPC_JAL: begin
				op_type_n = OP_JAL;
				op_c_n = imm_j;
			end
			default: rd_n = 5'd0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			d.decode_valid <= 1'b0;
			f.decode_complete <= 1'b0;
		end else begin
			f.decode_complete <= take;	// Releases the fetched word
			if (take) d.decode_valid <= 1'b1;
			else if (d.instr_complete) d.decode_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			d.op_a <= ra_rdata;
			d.op_b <= op_b_n;
			d.op_c <= op_c_n;
			d.op <= op_n;
			d.op_type <= op_type_n;
			d.rd <= rd_n;
			d.pc <= f.pc;
		end
	end

endmodule

// File: verilog/rv_exec.sv
//**********************************************************
// Execute stage: ALU, branch and jump targets, LW/SW on the
// data port and register writeback
//**********************************************************
module rv_exec import rv_pkg::*; (
	input  logic		clock,
	input  logic		reset,
	decode_if.exec		d,
	output logic [31:0]	next_pc,
	output logic [4:0]	rd_waddr,
	output logic [31:0]	rd_wdata,
	output logic		rd_wen,
	output logic		dvalid,
	output logic [31:0]	daddr,
	output logic [31:0]	dwdata,
	output logic [3:0]	dwstb,
	output logic		dwrite,
	input  logic [31:0]	drdata,
	input  logic		dready
);
	logic [31:0]	alu_out;
	logic [31:0]	pc_seq;
	logic [31:0]	pc_target;
	logic		start;
	logic		mem_done;

	assign pc_seq = d.pc + 32'd4;
	assign pc_target = d.pc + d.op_c;
	// Decode holds its bundle through the completion cycle
	assign start = d.decode_valid && !dvalid && !d.instr_complete;
	assign mem_done = dvalid && dready;
	assign dwstb = 4'b1111;	// Word accesses only

	always_comb begin
		case (d.op)
			ALU_SUB: alu_out = d.op_a - d.op_b;
			ALU_AND: alu_out = d.op_a & d.op_b;
			ALU_OR:  alu_out = d.op_a | d.op_b;
			ALU_XOR: alu_out = d.op_a ^ d.op_b;
			ALU_EQ:  alu_out = {31'b0, d.op_a == d.op_b};
			ALU_NE:  alu_out = {31'b0, d.op_a != d.op_b};
			default: alu_out = d.op_a + d.op_b;	// Also load/store address
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			d.instr_complete <= 1'b0;
			rd_wen <= 1'b0;
			dvalid <= 1'b0;
			dwrite <= 1'b0;
		end else begin
			d.instr_complete <= 1'b0;
			rd_wen <= 1'b0;
			if (start) begin
				case (d.op_type)
					OP_LOAD: dvalid <= 1'b1;
					OP_STORE: begin
						dvalid <= 1'b1;
						dwrite <= 1'b1;
					end
					OP_BRANCH: d.instr_complete <= 1'b1;
					default: begin	// ALU, LUI, JAL
						d.instr_complete <= 1'b1;
						rd_wen <= 1'b1;
					end
				endcase
			end else if (mem_done) begin
				dvalid <= 1'b0;
				dwrite <= 1'b0;
				d.instr_complete <= 1'b1;
				rd_wen <= !dwrite;	// Loads write back
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			daddr <= alu_out;
			dwdata <= d.op_c;
			rd_waddr <= d.rd;
			next_pc <= pc_seq;
			case (d.op_type)
				OP_LUI: rd_wdata <= d.op_b;
				OP_JAL: begin
					rd_wdata <= pc_seq;	// Link value
					next_pc <= pc_target;
				end
				OP_BRANCH: begin
					if (alu_out[0]) next_pc <= pc_target;
				end
				default: rd_wdata <= alu_out;
			endcase
		end else if (mem_done) begin
			rd_wdata <= drdata;
		end
	end

endmodule

// File: verilog/rv_core.sv
//**********************************************************
// Top level of the multi-cycle RV32I subset core
// Plain instruction and data ports toward the memory system
//**********************************************************
module rv_core (
	input  logic		clock,
	input  logic		reset,

	output logic [31:0]	iaddr,
	input  logic [31:0]	idata,
	output logic		ivalid,
	input  logic		iready,

	output logic		dvalid,
	output logic [31:0]	daddr,
	output logic [31:0]	dwdata,
	output logic [3:0]	dwstb,
	output logic		dwrite,
	input  logic [31:0]	drdata,
	input  logic		dready
);
	logic [31:0]	next_pc;
	logic [4:0]	ra_raddr;
	logic [4:0]	rb_raddr;
	logic [31:0]	ra_rdata;
	logic [31:0]	rb_rdata;
	logic [4:0]	rd_waddr;
	logic [31:0]	rd_wdata;
	logic		rd_wen;

	fetch_if fetch_bus ();
	decode_if decode_bus ();

	rv_fetch u_fetch (
		.clock		(clock),
		.reset		(reset),
		.next_pc	(next_pc),
		.instr_complete	(decode_bus.instr_complete),
		.iaddr		(iaddr),
		.idata		(idata),
		.ivalid		(ivalid),
		.iready		(iready),
		.f		(fetch_bus.fetch)
	);

	rv_regfile u_regfile (
		.clock		(clock),
		.reset		(reset),
		.ra_raddr	(ra_raddr),
		.rb_raddr	(rb_raddr),
		.ra_rdata	(ra_rdata),
		.rb_rdata	(rb_rdata),
		.rd_waddr	(rd_waddr),
		.rd_wdata	(rd_wdata),
		.rd_wen		(rd_wen)
	);

	rv_decode u_decode (
		.clock		(clock),
		.reset		(reset),
		.f		(fetch_bus.decode),
		.ra_raddr	(ra_raddr),
		.rb_raddr	(rb_raddr),
		.ra_rdata	(ra_rdata),
		.rb_rdata	(rb_rdata),
		.d		(decode_bus.decode)
	);

	rv_exec u_exec (
		.clock		(clock),
		.reset		(reset),
		.d		(decode_bus.exec),
		.next_pc	(next_pc),
		.rd_waddr	(rd_waddr),
		.rd_wdata	(rd_wdata),
		.rd_wen		(rd_wen),
		.dvalid		(dvalid),
		.daddr		(daddr),
		.dwdata		(dwdata),
		.dwstb		(dwstb),
		.dwrite		(dwrite),
		.drdata		(drdata),
		.dready		(dready)
	);

endmodule

// File: tb/tb_clock.sv
//**********************************************************
// Testbench clock (8 ns) and power-on reset for 4 cycles
//**********************************************************
module tb_clock (
	output logic	clock,
	output logic	reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;	// Released on a falling edge
	end

endmodule

// File: tb/tb_top.sv
//**********************************************************
// Testbench for rv_core with a shared memory model
// One program runs twice against a reference ISS, first
// without stalls and then with random stalls
//**********************************************************
`include "rv_settings.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	logic clock, reset, rerun_reset, core_reset;
	logic [31:0] iaddr, idata, daddr, dwdata, drdata;
	logic ivalid, iready, dvalid, dwrite, dready;
	logic [3:0] dwstb;
	logic [31:0] image [512];	// Program plus fill pattern
	logic [31:0] mem [512];
	logic [31:0] ref_mem [512];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_pc [$];
	integer seed, errors, prog_len, st_idx, pc_idx, rst_cycles, idelay, ddelay;
	integer watch_cycles, n_instr;
	logic use_delay, halted;
	logic [31:0] halt_addr;

	assign core_reset = reset || rerun_reset;

	tb_clock tb_clock_inst (.clock(clock), .reset(reset));

	rv_core rv_core_inst (
		.clock(clock), .reset(core_reset),
		.iaddr(iaddr), .idata(idata), .ivalid(ivalid), .iready(iready),
		.dvalid(dvalid), .daddr(daddr), .dwdata(dwdata), .dwstb(dwstb),
		.dwrite(dwrite), .drdata(drdata), .dready(dready)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] opc);
		logic [31:0] v;
		v = imm;
		return {v[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs2);
		logic [31:0] v;
		v = imm;
		return {v[11:5], rs2[4:0], 5'd0, 3'b010, v[4:0], 7'h23};	// Base is x0
	endfunction

	function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
		input int f3);
		logic [31:0] v;
		v = imm;
		return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:1], v[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input int imm, input int rd);
		logic [31:0] v;
		v = imm;
		return {v[20], v[10:1], v[11], v[19:12], rd[4:0], 7'h6f};
	endfunction

	task automatic emit(input logic [31:0] w);
		image[prog_len[8:0]] = w;
		prog_len++;
	endtask

	task automatic build_program();
		int r;
		for (int i = 0; i < 512; i++) image[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0193);
		prog_len = `RV_RESET_VECTOR >> 2;
		r = $random(seed);
		emit({r[31:12], 5'd1, 7'h37});	// LUI x1
		r = $random(seed);
		emit(enc_i(r, 0, 0, 2, 7'h13));
		emit(enc_i(r >> 12, 1, 0, 3, 7'h13));
		emit({7'h00, 5'd2, 5'd1, 3'd0, 5'd4, 7'h33});	// ADD
		emit({7'h20, 5'd3, 5'd4, 3'd0, 5'd5, 7'h33});	// SUB
		emit({7'h00, 5'd3, 5'd1, 3'd7, 5'd6, 7'h33});
		emit({7'h00, 5'd3, 5'd2, 3'd6, 5'd7, 7'h33});
		emit({7'h00, 5'd5, 5'd4, 3'd4, 5'd8, 7'h33});
		emit(enc_i(r >> 4, 3, 7, 9, 7'h13));
		emit(enc_i(r >> 8, 2, 6, 10, 7'h13));
		emit(enc_i(r >> 16, 1, 4, 11, 7'h13));
		emit(enc_i(5, 1, 0, 0, 7'h13));	// Write to x0
		for (int n = 0; n < 12; n++) emit(enc_s(32'h400 + 4 * n, n));
		for (int k = 0; k < 4; k++) begin
			r = 32'h700 + 4 * ($unsigned($random(seed)) % 64);
			emit(enc_s(r, 4 + k));
			emit(enc_i(r, 0, 2, 12, 7'h03));	// LW x12
			emit(enc_s(32'h500 + 4 * k, 12));
		end
		emit(enc_i(1, 0, 0, 13, 7'h13));
		emit(enc_i(1, 0, 0, 14, 7'h13));
		emit(enc_b(8, 14, 13, 0));	// Taken
		emit(enc_s(32'h600, 13));
		emit(enc_b(8, 14, 13, 1));	// Not taken
		emit(enc_s(32'h604, 14));
		emit(enc_b(8, 0, 13, 0));	// Not taken
		emit(enc_s(32'h608, 13));
		emit(enc_b(8, 0, 13, 1));	// Taken
		emit(enc_s(32'h60c, 13));
		emit(enc_j(8, 15));
		emit(enc_s(32'h610, 13));
		emit(enc_s(32'h614, 15));	// Link value
		emit(enc_i(3, 0, 0, 16, 7'h13));
		emit(enc_i(-1, 16, 0, 16, 7'h13));	// Countdown loop
		emit(enc_s(32'h618, 16));
		emit(enc_b(-8, 0, 16, 1));
		halt_addr = prog_len * 4;
		emit(enc_j(0, 0));	// Halt by jumping to itself
	endtask

	// Software model of the subset that fills the expected store and fetch lists
	function automatic int ref_iss();
		logic [31:0] x [32];
		logic [31:0] pc, ins, a, b, immi, imms, immb, wv, ea;
		logic [4:0] rd;
		int steps;
		exp_addr.delete();
		exp_data.delete();
		exp_pc.delete();
		for (int i = 0; i < 32; i++) x[i] = 0;
		for (int i = 0; i < 512; i++) ref_mem[i] = image[i];
		pc = `RV_RESET_VECTOR;
		steps = 0;
		while (steps < 5000) begin
			ins = ref_mem[pc[10:2]];
			exp_pc.push_back(pc);
			steps++;
			if (pc == halt_addr) break;
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			rd = ins[11:7];
			immi = {{20{ins[31]}}, ins[31:20]};
			imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			wv = 0;
			case (ins[6:0])
				7'h37: wv = {ins[31:12], 12'h0};
				7'h13, 7'h33: begin
					if (ins[6:0] == 7'h13) b = immi;
					case (ins[14:12])
						3'd0: wv = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
						3'd4: wv = a ^ b;
						3'd6: wv = a | b;
						default: wv = a & b;
					endcase
				end
				7'h03: begin
					ea = a + immi;
					wv = ref_mem[ea[10:2]];
				end
				7'h23: begin
					ea = a + imms;
					ref_mem[ea[10:2]] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
					rd = 0;
				end
				7'h63: begin
					if ((ins[12] == 1'b0) == (a == b)) pc = pc + immb - 4;
					rd = 0;
				end
				default: begin	// JAL
					wv = pc + 4;
					pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0} - 4;
				end
			endcase
			if (rd != 0) x[rd] = wv;
			pc = pc + 4;
		end
		return steps;
	endfunction

	task automatic load_memory();
		for (int i = 0; i < 512; i++) mem[i] = image[i];
	endtask

	function automatic int pick_delay();
		return use_delay ? $unsigned($random(seed)) % 4 : 0;
	endfunction

	// Memory model that drives both ports on the falling edge
	always @(negedge clock) begin
		if (rst_cycles > 0) begin
			iready = 1'b0;
			dready = 1'b0;
			idelay = pick_delay();
			ddelay = pick_delay();
		end else begin
			if (iready) iready = 1'b0;
			else if (ivalid && idelay > 0) idelay--;
			else if (ivalid) begin
				iready = 1'b1;
				idata = mem[iaddr[10:2]];
				idelay = pick_delay();
			end
			if (dready) dready = 1'b0;
			else if (dvalid && ddelay > 0) ddelay--;
			else if (dvalid) begin
				dready = 1'b1;
				drdata = mem[daddr[10:2]];
				if (dwrite) mem[daddr[10:2]] = dwdata;
				ddelay = pick_delay();
			end
		end
	end

	// Rising edges the DUT has seen in reset
	always @(posedge clock) begin
		if (core_reset) rst_cycles++;
		else rst_cycles = 0;
	end

	always @(negedge clock) begin
		if (rst_cycles > 0) begin
			check_value("reset ivalid", 0, {31'b0, ivalid});
			check_value("reset dvalid", 0, {31'b0, dvalid});
			check_value("reset dwrite", 0, {31'b0, dwrite});
		end
	end

	// Compare fetches and stores with the reference lists
	always @(posedge clock) begin
		if (!core_reset && !halted && ivalid && iready) begin
			if (pc_idx == 0) check_value("first iaddr", `RV_RESET_VECTOR, iaddr);
			if (pc_idx < exp_pc.size()) begin
				check_value($sformatf("fetch %0d iaddr", pc_idx), exp_pc[pc_idx], iaddr);
			end else begin
				errors++;
				$display("Fetch from %h beyond the predicted sequence", iaddr);
			end
			if (iaddr == halt_addr) halted = 1'b1;
			pc_idx++;
		end
		if (!core_reset && dvalid && dready && dwrite) begin
			if (st_idx < exp_addr.size()) begin
				check_value($sformatf("store %0d address", st_idx), exp_addr[st_idx], daddr);
				check_value($sformatf("store %0d data", st_idx), exp_data[st_idx], dwdata);
				check_value($sformatf("store %0d strobe", st_idx), 32'hf, {28'b0, dwstb});
			end else begin
				errors++;
				$display("Store to %h beyond the predicted list", daddr);
			end
			st_idx++;
		end
	end

	task automatic run_pass(input logic delayed);
		use_delay = delayed;
		@(negedge clock);
		rerun_reset = 1'b1;
		halted = 1'b0;
		pc_idx = 0;
		st_idx = 0;
		load_memory();
		repeat (4) @(negedge clock);
		rerun_reset = 1'b0;
		wait (halted);
		repeat (4) @(posedge clock);
		if (st_idx != exp_addr.size()) begin
			errors++;
			$display("Only %0d of %0d expected stores seen", st_idx, exp_addr.size());
		end
	endtask

	initial begin
		wait (watch_cycles != 0);
		repeat (watch_cycles) @(posedge clock);
		$display("Timeout: program did not reach its halt loop");
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		iready = 1'b0;
		dready = 1'b0;
		idata = '0;
		drdata = '0;
		rerun_reset = 1'b1;
		use_delay = 1'b0;
		halted = 1'b0;
		errors = 0;
		rst_cycles = 0;
		pc_idx = 0;
		st_idx = 0;
		seed = 32'h76d517c5;
		build_program();
		n_instr = ref_iss();
		watch_cycles = 2 * 200 * n_instr + 100;
		wait (!reset);
		run_pass(1'b0);
		run_pass(1'b1);
		$display("Done: %0d instructions per pass, %0d errors", n_instr, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_exec.sv
verilog/rv_core.sv
tb/tb_clock.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f vlog.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
